/* src/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Front end sizing
////////////////////////////////////////////////////////////////////////////

// Words in instruction memory
`define IMEM_DEPTH 64

// Word address and program counter width, log2 of the depth
`define IMEM_ADDR_W 6

// Instruction word width
`define INSTR_W 32

// Immediate field width inside the instruction word
`define IMM_W 16

`endif

/* src/isa_pkg.sv */
`include "fetch_config.svh"

////////////////////////////////////////////////////////////////////////////
// Instruction encoding types
////////////////////////////////////////////////////////////////////////////

package isa_pkg;

	// Primary opcode, bits 31..26
	// Values not listed here still decode as I-type
	typedef enum logic [5:0]
	{
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addi  = 6'h08,
		op_andi  = 6'h0c,
		op_ori   = 6'h0d,
		op_lui   = 6'h0f,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_t;

	// Instruction format
	typedef enum logic [1:0]
	{
		kind_r = 2'd0,
		kind_i = 2'd1,
		kind_j = 2'd2
	} instr_kind_t;

	// Fields split out of one instruction word
	typedef struct packed
	{
		opcode_t             opcode;
		logic [4:0]          rs;
		logic [4:0]          rt;
		logic [4:0]          rd;
		// Sign-extended immediate
		logic [`INSTR_W-1:0] imm;
		// Jump index, word address
		logic [25:0]         jump;
		instr_kind_t         kind;
	} decoded_t;

endpackage

/* src/pipe_pkg.sv */
`include "fetch_config.svh"

////////////////////////////////////////////////////////////////////////////
// Pipeline stage records
////////////////////////////////////////////////////////////////////////////

package pipe_pkg;

	import isa_pkg::*;

	// IF/ID record
	// Word address and raw word as read from memory
	typedef struct packed
	{
		logic [`IMEM_ADDR_W-1:0] pc;
		logic [`INSTR_W-1:0]     instr;
	} if_id_t;

	// ID/EX record
	// Raw word kept next to the decoded fields
	typedef struct packed
	{
		logic [`IMEM_ADDR_W-1:0] pc;
		logic [`INSTR_W-1:0]     instr;
		decoded_t                dec;
	} id_ex_t;

endpackage

/* src/stage_if.sv */
////////////////////////////////////////////////////////////////////////////
// Link between two pipeline stages
////////////////////////////////////////////////////////////////////////////

interface stage_if #(
	parameter type payload_t = logic
) ();

	// Word on offer from the stage in front
	logic     valid;
	payload_t payload;

	// Stall, the buffer keeps its contents
	logic     hold;

	// Kill the word being loaded
	logic     flush;

	// Stage that fills the link
	modport producer
	(
		output valid,
		output payload,
		input  hold
	);

	// Buffer that takes the word
	modport consumer
	(
		input valid,
		input payload,
		input hold,
		input flush
	);

endinterface

/* src/instruction_memory.sv */
`include "fetch_config.svh"

module instruction_memory
(
	input  logic                    clk,

	// Debug load port
	input  logic                    load_en,
	input  logic [`IMEM_ADDR_W-1:0] load_addr,
	input  logic [`INSTR_W-1:0]     load_data,

	// Fetch read port
	input  logic [`IMEM_ADDR_W-1:0] rd_addr,
	output logic [`INSTR_W-1:0]     rd_data
);

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////

	// Contents come only from the load port
	logic [`INSTR_W-1:0] mem [`IMEM_DEPTH];

	// Load port, one word per rising edge
	always_ff @(posedge clk)
	begin
		if (load_en)
		begin
			mem[load_addr] <= load_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read
	////////////////////////////////////////////////////////////////////////////

	// Asynchronous, word at the PC in the same cycle
	assign rd_data = mem[rd_addr];

endmodule

/* src/instruction_fetch.sv */
`include "fetch_config.svh"

module instruction_fetch
	import pipe_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,

	// Fetch enable and stall
	input  logic                    run,
	input  logic                    hold,

	// Jump from decode
	input  logic                    redirect,
	input  logic [`IMEM_ADDR_W-1:0] jump_target,

	// Debug load while run is low
	input  logic                    load_en,
	input  logic [`IMEM_ADDR_W-1:0] load_addr,
	input  logic [`INSTR_W-1:0]     load_data,

	// Toward IF/ID
	stage_if.producer               out_stage
);

	logic [`IMEM_ADDR_W-1:0] pc;
	logic [`IMEM_ADDR_W-1:0] pc_next;
	logic [`INSTR_W-1:0]     imem_word;
	logic                    advance;
	if_id_t                  fetch_word;

	instruction_memory u_imem
	(
		.clk       (clk),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.rd_addr   (pc),
		.rd_data   (imem_word)
	);

	////////////////////////////////////////////////////////////////////////////
	// Next address
	////////////////////////////////////////////////////////////////////////////

	// Word taken by IF/ID this cycle
	assign advance = run && !hold;

	always_comb
	begin
		pc_next = pc;
		// Jump wins over the sequential step
		if (redirect)
		begin
			pc_next = jump_target;
		end
		else if (advance)
		begin
			// Wrap at end of memory
			if (pc == `IMEM_ADDR_W'(`IMEM_DEPTH - 1))
			begin
				pc_next = '0;
			end
			else
			begin
				pc_next = pc + `IMEM_ADDR_W'(1);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc <= '0;
		end
		else
		begin
			pc <= pc_next;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Offer to IF/ID
	////////////////////////////////////////////////////////////////////////////

	assign fetch_word.pc    = pc;
	assign fetch_word.instr = imem_word;

	// Nothing on offer while halted
	assign out_stage.valid   = run;
	assign out_stage.payload = fetch_word;

	// Memory must not change under a running fetch
	a_load_idle: assert property (@(posedge clk) disable iff (rst) !(load_en && run));

endmodule

/* src/pipe_reg.sv */
module pipe_reg #(
	parameter type payload_t = logic
)
(
	input  logic      clk,
	input  logic      rst,

	// From the stage in front
	stage_if.consumer in_stage,

	// Registered word
	output logic      out_valid,
	output payload_t  out_payload
);

	////////////////////////////////////////////////////////////////////////////
	// Valid flag
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		// Flush beats hold
		if (rst || in_stage.flush)
		begin
			out_valid <= 1'b0;
		end
		else if (!in_stage.hold)
		begin
			out_valid <= in_stage.valid;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Payload
	////////////////////////////////////////////////////////////////////////////

	// Loads on every unstalled edge, valid says if it counts
	always_ff @(posedge clk)
	begin
		if (!in_stage.hold)
		begin
			out_payload <= in_stage.payload;
		end
	end

	// No X on valid once reset has been seen
	a_valid_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(out_valid));

	// Stalled record stays put for the next stage
	a_hold_stable: assert property (@(posedge clk) disable iff (rst)
		in_stage.hold && out_valid |=> $stable(out_payload));

endmodule

/* src/instruction_decode.sv */
`include "fetch_config.svh"

module instruction_decode
	import isa_pkg::*;
	import pipe_pkg::*;
(
	// From IF/ID
	input  logic                    in_valid,
	input  if_id_t                  in_payload,

	// Toward ID/EX
	stage_if.producer               out_stage,

	// Jump back to fetch
	output logic                    redirect,
	output logic [`IMEM_ADDR_W-1:0] jump_target,

	// Kill the wrong-path word in IF/ID
	output logic                    if_flush
);

	logic [`INSTR_W-1:0] instr;
	decoded_t            dec;
	id_ex_t              dec_word;
	logic                accept;

	assign instr = in_payload.instr;

	////////////////////////////////////////////////////////////////////////////
	// Field split
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		dec.opcode = opcode_t'(instr[31:26]);
		dec.rs     = instr[25:21];
		dec.rt     = instr[20:16];
		dec.rd     = instr[15:11];
		// Sign extend low half
		dec.imm    = {{(`INSTR_W - `IMM_W){instr[`IMM_W-1]}}, instr[`IMM_W-1:0]};
		dec.jump   = instr[25:0];

		// Format by opcode, anything unknown is I
		case (dec.opcode)
			op_rtype: dec.kind = kind_r;
			op_j:     dec.kind = kind_j;
			default:  dec.kind = kind_i;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Jump redirect
	////////////////////////////////////////////////////////////////////////////

	// ID/EX takes the record on this edge
	assign accept = !out_stage.hold;

	always_comb
	begin
		// Only once the J actually leaves IF/ID
		redirect = in_valid && accept && (dec.kind == kind_j);
		// Index is a word address, low bits only
		jump_target = dec.jump[`IMEM_ADDR_W-1:0];
		if_flush = redirect;

		// Raw opcode cross-check of the classification
		a_redirect_valid: assert (!redirect || (in_valid && instr[31:26] == 6'h02));
	end

	////////////////////////////////////////////////////////////////////////////
	// Offer to ID/EX
	////////////////////////////////////////////////////////////////////////////

	assign dec_word.pc    = in_payload.pc;
	assign dec_word.instr = instr;
	assign dec_word.dec   = dec;

	assign out_stage.valid   = in_valid;
	assign out_stage.payload = dec_word;

endmodule

/* src/fetch_decode_top.sv */
`include "fetch_config.svh"

module fetch_decode_top
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    run,
	input  logic                    stall,

	// Program load, run low only
	input  logic                    load_en,
	input  logic [`IMEM_ADDR_W-1:0] load_addr,
	input  logic [`INSTR_W-1:0]     load_data,

	// ID/EX record
	output logic                    out_valid,
	output logic [`IMEM_ADDR_W-1:0] out_pc,
	output logic [`INSTR_W-1:0]     out_instr,
	output instr_kind_t             out_kind,
	output opcode_t                 out_opcode,
	output logic [4:0]              out_rs,
	output logic [4:0]              out_rt,
	output logic [4:0]              out_rd,
	output logic [`INSTR_W-1:0]     out_imm,
	output logic [25:0]             out_jump
);

	stage_if #(.payload_t(if_id_t)) if_stage ();
	stage_if #(.payload_t(id_ex_t)) id_stage ();

	logic                    if_id_valid;
	if_id_t                  if_id_q;
	logic                    id_ex_valid;
	id_ex_t                  id_ex_q;
	logic                    redirect;
	logic [`IMEM_ADDR_W-1:0] jump_target;
	logic                    if_flush;

	////////////////////////////////////////////////////////////////////////////
	// Stall and flush routing
	////////////////////////////////////////////////////////////////////////////

	// One stall for the whole front end
	assign if_stage.hold  = stall;
	assign id_stage.hold  = stall;
	// Only a taken jump kills a word
	assign if_stage.flush = if_flush;
	assign id_stage.flush = 1'b0;

	instruction_fetch u_fetch
	(
		.clk         (clk),
		.rst         (rst),
		.run         (run),
		.hold        (stall),
		.redirect    (redirect),
		.jump_target (jump_target),
		.load_en     (load_en),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.out_stage   (if_stage.producer)
	);

	pipe_reg #(.payload_t(if_id_t)) u_if_id
	(
		.clk         (clk),
		.rst         (rst),
		.in_stage    (if_stage.consumer),
		.out_valid   (if_id_valid),
		.out_payload (if_id_q)
	);

	instruction_decode u_decode
	(
		.in_valid    (if_id_valid),
		.in_payload  (if_id_q),
		.out_stage   (id_stage.producer),
		.redirect    (redirect),
		.jump_target (jump_target),
		.if_flush    (if_flush)
	);

	pipe_reg #(.payload_t(id_ex_t)) u_id_ex
	(
		.clk         (clk),
		.rst         (rst),
		.in_stage    (id_stage.consumer),
		.out_valid   (id_ex_valid),
		.out_payload (id_ex_q)
	);

	////////////////////////////////////////////////////////////////////////////
	// Unpack ID/EX
	////////////////////////////////////////////////////////////////////////////

	assign out_valid  = id_ex_valid;
	assign out_pc     = id_ex_q.pc;
	assign out_instr  = id_ex_q.instr;
	assign out_kind   = id_ex_q.dec.kind;
	assign out_opcode = id_ex_q.dec.opcode;
	assign out_rs     = id_ex_q.dec.rs;
	assign out_rt     = id_ex_q.dec.rt;
	assign out_rd     = id_ex_q.dec.rd;
	assign out_imm    = id_ex_q.dec.imm;
	assign out_jump   = id_ex_q.dec.jump;

endmodule

/* sim/tb_fetch_decode.sv */
`include "fetch_config.svh"

module tb_fetch_decode;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD     = 100;
	localparam int RESET_CYCLES   = 16;
	localparam int MID_RESET      = 4;
	localparam int LOAD_CYCLES    = `IMEM_DEPTH + 8;
	localparam int RECORDS_FIRST  = 300;
	localparam int RECORDS_SECOND = 200;
	localparam int RECORDS_TOTAL  = RECORDS_FIRST + RECORDS_SECOND;
	// Four cycles per record is far above stalls plus jump bubbles
	localparam longint TIMEOUT_NS = longint'(RECORDS_TOTAL * 4 + RESET_CYCLES + MID_RESET
		+ LOAD_CYCLES) * CLK_PERIOD;

	logic                    clk = 1'b0;
	logic                    rst;
	logic                    run;
	logic                    stall;
	logic                    load_en;
	logic [`IMEM_ADDR_W-1:0] load_addr;
	logic [`INSTR_W-1:0]     load_data;

	logic                    out_valid;
	logic [`IMEM_ADDR_W-1:0] out_pc;
	logic [`INSTR_W-1:0]     out_instr;
	logic [1:0]              out_kind;
	logic [5:0]              out_opcode;
	logic [4:0]              out_rs;
	logic [4:0]              out_rt;
	logic [4:0]              out_rd;
	logic [`INSTR_W-1:0]     out_imm;
	logic [25:0]             out_jump;

	// LCG state
	logic [31:0]             seed = 32'd14;

	// Program as loaded into memory
	logic [`INSTR_W-1:0]     prog [`IMEM_DEPTH];

	// Architectural PC of the next expected record
	logic [`IMEM_ADDR_W-1:0] exp_pc;

	int record_count   = 0;
	int check_count    = 0;
	int mismatch_count = 0;
	int error_count    = 0;
	int jump_count     = 0;
	int wrap_count     = 0;

	// Previous sample for the stall hold check
	logic                    prev_stall = 1'b0;
	logic                    prev_rst   = 1'b1;
	logic                    last_valid;
	logic [`IMEM_ADDR_W-1:0] last_pc;
	logic [`INSTR_W-1:0]     last_instr;

	fetch_decode_top UUT
	(
		.clk        (clk),
		.rst        (rst),
		.run        (run),
		.stall      (stall),
		.load_en    (load_en),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.out_valid  (out_valid),
		.out_pc     (out_pc),
		.out_instr  (out_instr),
		.out_kind   (out_kind),
		.out_opcode (out_opcode),
		.out_rs     (out_rs),
		.out_rt     (out_rt),
		.out_rd     (out_rd),
		.out_imm    (out_imm),
		.out_jump   (out_jump)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Random stimulus
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// About 1 in 8 J, 1 in 4 R, rest I-type
	function automatic logic [31:0] random_word();
		logic [31:0] sel;
		logic [31:0] body;
		logic [5:0]  opc;
		sel  = lcg_next();
		body = lcg_next();
		case (sel[31:29])
			3'd0: opc = 6'h02;
			3'd1, 3'd2: opc = 6'h00;
			default:
			begin
				opc = sel[25:20];
				// Keep J at its own rate
				if (opc == 6'h02)
				begin
					opc = 6'h08;
				end
			end
		endcase
		return {opc, body[25:0]};
	endfunction

	// Jump target between the J and the last address
	function automatic logic [`IMEM_ADDR_W-1:0] forward_target(input int addr);
		logic [31:0] r;
		int          span;
		r    = lcg_next();
		span = `IMEM_DEPTH - 1 - addr;
		return `IMEM_ADDR_W'(addr + 1 + int'(r[15:0] % span));
	endfunction

	// Stall about one cycle in four
	function automatic logic random_stall();
		logic [31:0] r;
		r = lcg_next();
		return r[31:30] == 2'b00;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks and model
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected)
		begin
			mismatch_count++;
			$display("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	// Field split straight from the MIPS encoding
	task automatic check_record();
		logic [31:0] word;
		logic [5:0]  opc;
		logic [1:0]  kind;
		word = prog[exp_pc];
		opc  = word[31:26];
		if (opc == 6'h00)
		begin
			kind = 2'd0;
		end
		else if (opc == 6'h02)
		begin
			kind = 2'd2;
		end
		else
		begin
			kind = 2'd1;
		end
		check_value("out_pc", 32'(out_pc), 32'(exp_pc));
		check_value("out_instr", out_instr, word);
		check_value("out_kind", 32'(out_kind), 32'(kind));
		check_value("out_opcode", 32'(out_opcode), 32'(opc));
		check_value("out_rs", 32'(out_rs), 32'(word[25:21]));
		check_value("out_rt", 32'(out_rt), 32'(word[20:16]));
		check_value("out_rd", 32'(out_rd), 32'(word[15:11]));
		check_value("out_imm", out_imm, {{16{word[15]}}, word[15:0]});
		check_value("out_jump", 32'(out_jump), {6'd0, word[25:0]});

		// Next address on the architectural path
		if (opc == 6'h02)
		begin
			// Low index bits give the modulo of a power-of-two depth
			exp_pc = word[`IMEM_ADDR_W-1:0];
			jump_count++;
		end
		else if (exp_pc == `IMEM_ADDR_W'(`IMEM_DEPTH - 1))
		begin
			exp_pc = '0;
			wrap_count++;
		end
		else
		begin
			exp_pc = exp_pc + `IMEM_ADDR_W'(1);
		end
	endtask

	// Sample half a cycle after the drive edge when everything has settled
	always @(negedge clk)
	begin
		if (rst)
		begin
			exp_pc = '0;
		end
		else
		begin
			// Halted fetch offers nothing
			if (!run)
			begin
				check_value("out_valid while halted", 32'(out_valid), 32'd0);
			end
			// Stalled edge must leave the record alone
			if (prev_stall && !prev_rst)
			begin
				check_value("held out_valid", 32'(out_valid), 32'(last_valid));
				check_value("held out_pc", 32'(out_pc), 32'(last_pc));
				check_value("held out_instr", out_instr, last_instr);
			end
			// Record leaves ID/EX at the coming edge
			if (out_valid && !stall)
			begin
				check_record();
				record_count++;
			end
		end
		prev_stall = stall;
		prev_rst   = rst;
		last_valid = out_valid;
		last_pc    = out_pc;
		last_instr = out_instr;
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		rst       = 1'b1;
		run       = 1'b0;
		stall     = 1'b0;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		for (int a = 0; a < `IMEM_DEPTH; a++)
		begin
			prog[a] = random_word();
			// Only forward jumps so that every lap passes the last word and wraps
			if (prog[a][31:26] == 6'h02)
			begin
				if (a == `IMEM_DEPTH - 1)
				begin
					// Last word never jumps since any target lies behind it
					prog[a][31:26] = 6'h08;
				end
				else
				begin
					prog[a][`IMEM_ADDR_W-1:0] = forward_target(a);
				end
			end
		end

		repeat (RESET_CYCLES) @(posedge clk);
		#5;
		rst = 1'b0;

		// Program load through the debug port while fetch is halted
		for (int a = 0; a < `IMEM_DEPTH; a++)
		begin
			@(posedge clk);
			#5;
			load_en   = 1'b1;
			load_addr = `IMEM_ADDR_W'(a);
			load_data = prog[a];
		end
		@(posedge clk);
		#5;
		load_en = 1'b0;
		repeat (3) @(posedge clk);
		#5;
		run = 1'b1;

		while (record_count < RECORDS_FIRST)
		begin
			@(posedge clk);
			#5;
			stall = random_stall();
		end

		// Reset in mid-run with the program kept in memory
		@(posedge clk);
		#5;
		stall = 1'b0;
		rst   = 1'b1;
		@(posedge clk);
		@(negedge clk);
		check_value("out_valid in reset", 32'(out_valid), 32'd0);
		repeat (MID_RESET - 1) @(posedge clk);
		#5;
		rst = 1'b0;

		while (record_count < RECORDS_TOTAL)
		begin
			@(posedge clk);
			#5;
			stall = random_stall();
		end
		@(posedge clk);
		#5;
		stall = 1'b0;

		$display("Records %0d, jumps %0d, wraps %0d, checks %0d, mismatches %0d, errors %0d",
			record_count, jump_count, wrap_count, check_count, mismatch_count, error_count);
		if (mismatch_count == 0 && error_count == 0)
		begin
			$display("Testbench passed");
		end
		else
		begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_NS);
		error_count++;
		$display("Timeout: only %0d of %0d records came out within %0d ns",
			record_count, RECORDS_TOTAL, $time);
		$display("Records %0d, jumps %0d, wraps %0d, checks %0d, mismatches %0d, errors %0d",
			record_count, jump_count, wrap_count, check_count, mismatch_count, error_count);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/stage_if.sv
src/instruction_memory.sv
src/instruction_fetch.sv
src/pipe_reg.sv
src/instruction_decode.sv
src/fetch_decode_top.sv
sim/tb_fetch_decode.sv

/* Makefile */
# Verilator build and run of the fetch and decode front end

TOP       ?= tb_fetch_decode
RTL_TOP   ?= fetch_decode_top
LOG       ?= sim.log
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
LINT_OPTS ?= --lint-only --timing --timescale 1ns/1ps
OBJ_DIR   ?= obj_dir

FILELIST  := vlog.f
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard src/*.svh)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Result comes from the log, not the exit status
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "Testbench passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_OPTS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_OPTS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
